/* Bender.yml */
package:
  name: riscv_core

export_include_dirs:
  - include

sources:
  - rtl/riscv_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/load_store_unit.sv
  - rtl/pc_unit.sv
  - rtl/riscv_core.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/riscv_core_props.sv
      - verification/riscv_core_tb.sv

/* include/riscv_macros.svh */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// base opcodes
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`define RV_OP_MISC_MEM 7'b0001111
`define RV_OP_SYSTEM   7'b1110011

// funct3 for integer ops
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// funct3 for branches
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// funct3 for load/store size
`define RV_F3_BYTE   3'b000
`define RV_F3_HALF   3'b001
`define RV_F3_WORD   3'b010
`define RV_F3_BYTE_U 3'b100
`define RV_F3_HALF_U 3'b101

// sub and sra
`define RV_F7_ALT 7'b0100000

`define RV_RESET_PC   32'h0000_0000
`define RV_INSN_BYTES 32'd4

`endif

/* riscv_core.f */
+incdir+include
rtl/riscv_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/load_store_unit.sv
rtl/pc_unit.sv
rtl/riscv_core.sv
verification/tb_clock_gen.sv
verification/riscv_core_props.sv
verification/riscv_core_tb.sv

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "riscv_macros.svh"

module alu (
  input  riscv_pkg::word_t   i_a,
  input  riscv_pkg::word_t   i_b,
  input  riscv_pkg::funct3_t i_funct3,
  input  logic               i_alt,
  input  logic               i_is_reg,
  output riscv_pkg::word_t   o_result
);

  riscv_pkg::shamt_t shamt;
  logic              sub_en;

  assign shamt = i_b[4:0];

  // addi has no sub form, its imm[10] is just data
  assign sub_en = i_alt & i_is_reg;

  always_comb begin
    case (i_funct3)
      `RV_F3_ADD:  o_result = sub_en ? (i_a - i_b) : (i_a + i_b);
      `RV_F3_SLL:  o_result = i_a << shamt;
      `RV_F3_SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
      `RV_F3_SLTU: o_result = {31'b0, i_a < i_b};
      `RV_F3_XOR:  o_result = i_a ^ i_b;
      `RV_F3_SR: begin
        // srai and sra share funct7 bit 5
        if (i_alt) begin
          o_result = $signed(i_a) >>> shamt;
        end else begin
          o_result = i_a >> shamt;
        end
      end
      `RV_F3_OR:   o_result = i_a | i_b;
      default:     o_result = i_a & i_b;
    endcase
  end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`include "riscv_macros.svh"

module instr_decoder (
  input  riscv_pkg::word_t     i_insn,
  output riscv_pkg::reg_addr_t o_rs1,
  output riscv_pkg::reg_addr_t o_rs2,
  output riscv_pkg::reg_addr_t o_rd,
  output riscv_pkg::funct3_t   o_funct3,
  output riscv_pkg::funct7_t   o_funct7,
  output riscv_pkg::word_t     o_imm_i,
  output riscv_pkg::word_t     o_imm_s,
  output riscv_pkg::word_t     o_imm_b,
  output riscv_pkg::word_t     o_imm_j,
  output riscv_pkg::word_t     o_imm_u,
  output logic                 o_is_lui,
  output logic                 o_is_auipc,
  output logic                 o_is_jal,
  output logic                 o_is_jalr,
  output logic                 o_is_branch,
  output logic                 o_is_load,
  output logic                 o_is_store,
  output logic                 o_is_op_imm,
  output logic                 o_is_op_reg,
  output logic                 o_is_ecall
);

  riscv_pkg::opcode_t opcode;

  // fields sit at the fixed R-type positions
  assign opcode   = i_insn[6:0];
  assign o_rd     = i_insn[11:7];
  assign o_funct3 = i_insn[14:12];
  assign o_rs1    = i_insn[19:15];
  assign o_rs2    = i_insn[24:20];
  assign o_funct7 = i_insn[31:25];

  // I, S, B and J immediates sign-extend from bit 31
  assign o_imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign o_imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign o_imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                    i_insn[11:8], 1'b0};
  assign o_imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                    i_insn[30:21], 1'b0};
  assign o_imm_u = {i_insn[31:12], 12'b0};

  // one-hot class flags
  assign o_is_lui    = opcode == `RV_OP_LUI;
  assign o_is_auipc  = opcode == `RV_OP_AUIPC;
  assign o_is_jal    = opcode == `RV_OP_JAL;
  assign o_is_jalr   = opcode == `RV_OP_JALR;
  assign o_is_branch = opcode == `RV_OP_BRANCH;
  assign o_is_load   = opcode == `RV_OP_LOAD;
  assign o_is_store  = opcode == `RV_OP_STORE;
  assign o_is_op_imm = opcode == `RV_OP_IMM;
  assign o_is_op_reg = opcode == `RV_OP_REG;

  // ebreak and csr forms fall through as no-ops
  assign o_is_ecall = (opcode == `RV_OP_SYSTEM) && (i_insn[31:7] == 25'd0);

endmodule

/* rtl/load_store_unit.sv */
`timescale 1ns/1ps
`include "riscv_macros.svh"

module load_store_unit (
  input  riscv_pkg::word_t    i_base,
  input  riscv_pkg::word_t    i_imm_i,
  input  riscv_pkg::word_t    i_imm_s,
  input  logic                i_is_load,
  input  logic                i_is_store,
  input  riscv_pkg::funct3_t  i_funct3,
  input  riscv_pkg::word_t    i_store_src,
  input  riscv_pkg::word_t    i_load_data,
  output riscv_pkg::word_t    o_dmem_addr,
  output riscv_pkg::word_t    o_store_data,
  output riscv_pkg::byte_en_t o_store_we,
  output riscv_pkg::word_t    o_load_result
);

  riscv_pkg::word_t    eff_addr;
  riscv_pkg::word_t    lane_data;
  riscv_pkg::byte_en_t store_mask;
  logic [1:0]          offset;

  assign eff_addr    = i_base + (i_is_store ? i_imm_s : i_imm_i);
  assign offset      = eff_addr[1:0];
  assign o_dmem_addr = {eff_addr[31:2], 2'b00};

  // addressed byte moved down to lane 0
  assign lane_data = i_load_data >> {offset, 3'b000};

  // data replicated into every lane so the strobe picks one
  always_comb begin
    o_store_data = i_store_src;
    store_mask   = '0;
    case (i_funct3)
      `RV_F3_BYTE: begin
        o_store_data = {4{i_store_src[7:0]}};
        store_mask   = 4'b0001 << offset;
      end
      `RV_F3_HALF: begin
        o_store_data = {2{i_store_src[15:0]}};
        if (!offset[0]) begin
          store_mask = offset[1] ? 4'b1100 : 4'b0011;
        end
      end
      `RV_F3_WORD: begin
        if (offset == 2'b00) begin
          store_mask = 4'b1111;
        end
      end
      default: store_mask = '0;
    endcase
  end

  assign o_store_we = i_is_store ? store_mask : '0;

  // load extraction and extension
  always_comb begin
    o_load_result = '0;
    if (i_is_load) begin
      case (i_funct3)
        `RV_F3_BYTE:   o_load_result = {{24{lane_data[7]}}, lane_data[7:0]};
        `RV_F3_BYTE_U: o_load_result = {24'b0, lane_data[7:0]};
        `RV_F3_HALF: begin
          if (!offset[0]) begin
            o_load_result = {{16{lane_data[15]}}, lane_data[15:0]};
          end
        end
        `RV_F3_HALF_U: begin
          if (!offset[0]) begin
            o_load_result = {16'b0, lane_data[15:0]};
          end
        end
        `RV_F3_WORD: begin
          if (offset == 2'b00) begin
            o_load_result = i_load_data;
          end
        end
        default: o_load_result = '0;
      endcase
    end
  end

endmodule

/* rtl/pc_unit.sv */
`timescale 1ns/1ps
`include "riscv_macros.svh"

module pc_unit (
  input  logic               clk,
  input  logic               rst,
  input  riscv_pkg::word_t   i_rs1_data,
  input  riscv_pkg::word_t   i_rs2_data,
  input  riscv_pkg::funct3_t i_funct3,
  input  riscv_pkg::word_t   i_imm_b,
  input  riscv_pkg::word_t   i_imm_j,
  input  riscv_pkg::word_t   i_imm_i,
  input  logic               i_is_branch,
  input  logic               i_is_jal,
  input  logic               i_is_jalr,
  input  logic               i_is_ecall,
  output riscv_pkg::word_t   o_pc,
  output riscv_pkg::word_t   o_pc_plus4,
  output logic               o_running,
  output logic               o_halt
);

  riscv_pkg::word_t      pc_q;
  riscv_pkg::word_t      next_pc;
  riscv_pkg::word_t      jalr_sum;
  riscv_pkg::run_state_t state_q;
  logic                  take_branch;

  assign o_pc_plus4 = pc_q + `RV_INSN_BYTES;
  assign jalr_sum   = i_rs1_data + i_imm_i;

  always_comb begin
    case (i_funct3)
      `RV_F3_BEQ:  take_branch = i_rs1_data == i_rs2_data;
      `RV_F3_BNE:  take_branch = i_rs1_data != i_rs2_data;
      `RV_F3_BLT:  take_branch = $signed(i_rs1_data) < $signed(i_rs2_data);
      `RV_F3_BGE:  take_branch = $signed(i_rs1_data) >= $signed(i_rs2_data);
      `RV_F3_BLTU: take_branch = i_rs1_data < i_rs2_data;
      `RV_F3_BGEU: take_branch = i_rs1_data >= i_rs2_data;
      default:     take_branch = 1'b0;
    endcase
  end

  // ecall parks the pc on itself
  always_comb begin
    next_pc = o_pc_plus4;
    if (i_is_ecall) begin
      next_pc = pc_q;
    end else if (i_is_jal) begin
      next_pc = pc_q + i_imm_j;
    end else if (i_is_jalr) begin
      next_pc = {jalr_sum[31:1], 1'b0};
    end else if (i_is_branch && take_branch) begin
      next_pc = pc_q + i_imm_b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `RV_RESET_PC;
      state_q <= riscv_pkg::RUNNING;
    end else if (state_q == riscv_pkg::RUNNING) begin
      pc_q <= next_pc;
      if (i_is_ecall) begin
        state_q <= riscv_pkg::HALTED;
      end
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = state_q == riscv_pkg::HALTED;

  // no side effects while reset is held
  assign o_running = (state_q == riscv_pkg::RUNNING) && !rst;

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_we,
  input  riscv_pkg::reg_addr_t i_rd,
  input  riscv_pkg::word_t     i_rd_data,
  input  riscv_pkg::reg_addr_t i_rs1,
  input  riscv_pkg::reg_addr_t i_rs2,
  output riscv_pkg::word_t     o_rs1_data,
  output riscv_pkg::word_t     o_rs2_data
);

  riscv_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // x0 reads zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
  input  logic                clk,
  input  logic                rst,
  output riscv_pkg::word_t    o_pc,
  input  riscv_pkg::word_t    i_insn,
  output riscv_pkg::word_t    o_dmem_addr,
  input  riscv_pkg::word_t    i_load_data,
  output riscv_pkg::word_t    o_store_data,
  output riscv_pkg::byte_en_t o_store_we,
  output logic                o_halt
);

  riscv_pkg::reg_addr_t rs1;
  riscv_pkg::reg_addr_t rs2;
  riscv_pkg::reg_addr_t rd;
  riscv_pkg::funct3_t   funct3;
  riscv_pkg::funct7_t   funct7;
  riscv_pkg::word_t     imm_i;
  riscv_pkg::word_t     imm_s;
  riscv_pkg::word_t     imm_b;
  riscv_pkg::word_t     imm_j;
  riscv_pkg::word_t     imm_u;
  riscv_pkg::word_t     rs1_data;
  riscv_pkg::word_t     rs2_data;
  riscv_pkg::word_t     rd_data;
  riscv_pkg::word_t     alu_b;
  riscv_pkg::word_t     alu_result;
  riscv_pkg::word_t     load_result;
  riscv_pkg::word_t     pc_plus4;
  logic is_lui;
  logic is_auipc;
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic is_load;
  logic is_store;
  logic is_op_imm;
  logic is_op_reg;
  logic is_ecall;
  logic running;
  logic rf_we;

  instr_decoder u_decoder (
    .i_insn      (i_insn),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_funct3    (funct3),
    .o_funct7    (funct7),
    .o_imm_i     (imm_i),
    .o_imm_s     (imm_s),
    .o_imm_b     (imm_b),
    .o_imm_j     (imm_j),
    .o_imm_u     (imm_u),
    .o_is_lui    (is_lui),
    .o_is_auipc  (is_auipc),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_is_branch (is_branch),
    .o_is_load   (is_load),
    .o_is_store  (is_store),
    .o_is_op_imm (is_op_imm),
    .o_is_op_reg (is_op_reg),
    .o_is_ecall  (is_ecall)
  );

  // fence, branches, stores and ecall leave rd alone
  assign rf_we = running & (is_lui | is_auipc | is_jal | is_jalr | is_load |
                            is_op_imm | is_op_reg);

  always_comb begin
    if (is_lui) begin
      rd_data = imm_u;
    end else if (is_auipc) begin
      rd_data = o_pc + imm_u;
    end else if (is_jal || is_jalr) begin
      rd_data = pc_plus4;
    end else if (is_load) begin
      rd_data = load_result;
    end else begin
      rd_data = alu_result;
    end
  end

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_we       (rf_we),
    .i_rd       (rd),
    .i_rd_data  (rd_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_b = is_op_reg ? rs2_data : imm_i;

  // funct7 bit 5 picks sub and arithmetic shift
  alu u_alu (
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .i_funct3 (funct3),
    .i_alt    (funct7[5]),
    .i_is_reg (is_op_reg),
    .o_result (alu_result)
  );

  // strobes stay low unless the core is running
  load_store_unit u_lsu (
    .i_base        (rs1_data),
    .i_imm_i       (imm_i),
    .i_imm_s       (imm_s),
    .i_is_load     (is_load),
    .i_is_store    (is_store & running),
    .i_funct3      (funct3),
    .i_store_src   (rs2_data),
    .i_load_data   (i_load_data),
    .o_dmem_addr   (o_dmem_addr),
    .o_store_data  (o_store_data),
    .o_store_we    (o_store_we),
    .o_load_result (load_result)
  );

  pc_unit u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_funct3    (funct3),
    .i_imm_b     (imm_b),
    .i_imm_j     (imm_j),
    .i_imm_i     (imm_i),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_is_ecall  (is_ecall),
    .o_pc        (o_pc),
    .o_pc_plus4  (pc_plus4),
    .o_running   (running),
    .o_halt      (o_halt)
  );

endmodule

/* rtl/riscv_pkg.sv */
package riscv_pkg;

  // register, data and address word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // one strobe per byte lane
  typedef logic [3:0] byte_en_t;

  typedef logic [4:0] shamt_t;

  // halt is sticky until reset
  typedef enum logic {
    RUNNING,
    HALTED
  } run_state_t;

endpackage

/* verification/riscv_core_props.sv */
`timescale 1ns/1ps

module riscv_core_props (
  input logic                clk,
  input logic                rst,
  input riscv_pkg::word_t    i_pc,
  input riscv_pkg::byte_en_t i_store_we,
  input logic                i_halt
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  pc_word_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else begin
      $error("o_pc 0x%08h is not word-aligned", i_pc);
      fail_count++;
    end

  no_store_when_halted: assert property (
    @(posedge clk) disable iff (rst) i_halt |-> (i_store_we == '0))
    else begin
      $error("o_store_we 0x%1h while o_halt is high", i_store_we);
      fail_count++;
    end

  // halt parks the pc until the next reset
  pc_held_when_halted: assert property (
    @(posedge clk) disable iff (rst) i_halt |=> $stable(i_pc))
    else begin
      $error("o_pc moved to 0x%08h after halt", i_pc);
      fail_count++;
    end

endmodule

bind riscv_core riscv_core_props u_props (
  .clk        (clk),
  .rst        (rst),
  .i_pc       (o_pc),
  .i_store_we (o_store_we),
  .i_halt     (o_halt)
);

/* verification/riscv_core_tb.sv */
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_core_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = 200;
  localparam int NUM_TESTS    = 6;
  localparam int DRIVE_DELAY  = 1;
  localparam int MEM_WORDS    = 256;
  // results land at byte 0x200
  localparam int RES_WORD     = 128;
  localparam int WATCHDOG_NS  = (NUM_TESTS * (MAX_CYCLES + 10) + RESET_CYCLES) * CLK_PERIOD;

  logic                clk;
  logic                por_rst;
  logic                test_rst;
  logic                rst;
  riscv_pkg::word_t    pc;
  riscv_pkg::word_t    insn;
  riscv_pkg::word_t    dmem_addr;
  riscv_pkg::word_t    load_data;
  riscv_pkg::word_t    store_data;
  riscv_pkg::byte_en_t store_we;
  logic                halt;

  riscv_pkg::word_t mem [MEM_WORDS];
  riscv_pkg::word_t exp_q [$];
  string            name_q [$];
  int               prog_idx = 0;
  int               result_count = 0;
  int               errors = 0;
  int               checks = 0;

  tb_clock_gen u_clock_gen (
    .o_clk (clk),
    .o_rst (por_rst)
  );

  assign rst = por_rst | test_rst;

  riscv_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem_addr  (dmem_addr),
    .i_load_data  (load_data),
    .o_store_data (store_data),
    .o_store_we   (store_we),
    .o_halt       (halt)
  );

  // async reads and byte-lane writes at the rising edge
  assign insn      = mem[pc[9:2]];
  assign load_data = mem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (store_we[k]) begin
        mem[dmem_addr[9:2]][8*k +: 8] <= store_data[8*k +: 8];
      end
    end
  end

  // instruction encoders
  function automatic riscv_pkg::word_t r_type(input riscv_pkg::funct7_t f7,
      input riscv_pkg::funct3_t f3, input riscv_pkg::reg_addr_t rd,
      input riscv_pkg::reg_addr_t rs1, input riscv_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic riscv_pkg::word_t i_type(input riscv_pkg::opcode_t op,
      input riscv_pkg::funct3_t f3, input riscv_pkg::reg_addr_t rd,
      input riscv_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic riscv_pkg::word_t s_type(input riscv_pkg::funct3_t f3,
      input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1,
      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic riscv_pkg::word_t b_type(input riscv_pkg::funct3_t f3,
      input riscv_pkg::reg_addr_t rs1, input riscv_pkg::reg_addr_t rs2,
      input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic riscv_pkg::word_t u_type(input riscv_pkg::opcode_t op,
      input riscv_pkg::reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic riscv_pkg::word_t j_type(input riscv_pkg::reg_addr_t rd,
      input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic riscv_pkg::word_t ecall_insn();
    return {25'd0, `RV_OP_SYSTEM};
  endfunction

  function automatic riscv_pkg::word_t addi(input riscv_pkg::reg_addr_t rd,
      input riscv_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return i_type(`RV_OP_IMM, `RV_F3_ADD, rd, rs1, imm);
  endfunction

  // background word holds its own byte address
  function automatic riscv_pkg::word_t fill_word(input int idx);
    return 32'hc0de_0000 | (riscv_pkg::word_t'(idx) << 2);
  endfunction

  function automatic riscv_pkg::word_t pc_here();
    return riscv_pkg::word_t'(prog_idx) << 2;
  endfunction

  task automatic check_word(input string name, input riscv_pkg::word_t got,
      input riscv_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_strobe(input string name, input riscv_pkg::byte_en_t got,
      input riscv_pkg::byte_en_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%1h, expected 0x%1h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%1h, expected 0x%1h", name, got, exp);
    end
  endtask

  task automatic clear_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= fill_word(i);
    end
    prog_idx     = 0;
    result_count = 0;
    exp_q.delete();
    name_q.delete();
  endtask

  task automatic restart_core();
    @(posedge clk);
    #DRIVE_DELAY;
    test_rst = 1'b1;
    clear_memory();
  endtask

  task automatic emit(input riscv_pkg::word_t word);
    mem[prog_idx] <= word;
    prog_idx++;
  endtask

  // sw of one register into the next result slot
  task automatic store_result(input riscv_pkg::reg_addr_t rs,
      input riscv_pkg::word_t exp, input string name);
    emit(s_type(`RV_F3_WORD, rs, 5'd1, 12'(result_count * 4)));
    exp_q.push_back(exp);
    name_q.push_back(name);
    result_count++;
  endtask

  task automatic emit_result(input riscv_pkg::word_t word, input riscv_pkg::word_t exp,
      input string name);
    emit(word);
    store_result(5'd4, exp, name);
  endtask

  task automatic wait_for_halt(input string test_name);
    int cycles;
    cycles = 0;
    while (!halt && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      errors++;
      $display("%s: program did not reach ecall within %0d cycles", test_name, MAX_CYCLES);
    end
  endtask

  task automatic run_program(input string test_name);
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    test_rst = 1'b0;
    wait_for_halt(test_name);
  endtask

  task automatic check_results();
    for (int i = 0; i < exp_q.size(); i++) begin
      check_word($sformatf("mem[0x%03h] %s", 32'h200 + 4 * i, name_q[i]),
                 mem[RES_WORD + i], exp_q[i]);
    end
  endtask

  // runs inside the power-on reset
  task automatic reset_test();
    clear_memory();
    emit(s_type(`RV_F3_WORD, 5'd0, 5'd0, 12'h200));
    emit(ecall_insn());
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_word("o_pc", pc, `RV_RESET_PC);
    check_flag("o_halt", halt, 1'b0);
    check_strobe("o_store_we", store_we, 4'h0);
    wait (!por_rst);
    @(negedge clk);
    check_word("o_pc", pc, `RV_RESET_PC);
    check_flag("o_halt", halt, 1'b0);
    wait_for_halt("reset");
    check_word("mem[0x200]", mem[RES_WORD], 32'h0);
  endtask

  task automatic alu_test();
    riscv_pkg::word_t a;
    riscv_pkg::word_t b;
    a = 32'hffff_ff9c;
    b = 32'd7;
    restart_core();
    emit(addi(5'd1, 5'd0, 12'h200));
    emit(addi(5'd2, 5'd0, 12'hf9c));
    emit(addi(5'd3, 5'd0, 12'd7));
    emit_result(r_type(7'd0, `RV_F3_ADD, 5'd4, 5'd2, 5'd3), a + b, "add");
    emit_result(r_type(`RV_F7_ALT, `RV_F3_ADD, 5'd4, 5'd2, 5'd3), a - b, "sub");
    emit_result(r_type(7'd0, `RV_F3_SLT, 5'd4, 5'd2, 5'd3), 32'd1, "slt");
    emit_result(r_type(7'd0, `RV_F3_SLTU, 5'd4, 5'd2, 5'd3), 32'd0, "sltu");
    emit_result(r_type(7'd0, `RV_F3_XOR, 5'd4, 5'd2, 5'd3), a ^ b, "xor");
    emit_result(r_type(7'd0, `RV_F3_OR, 5'd4, 5'd2, 5'd3), a | b, "or");
    emit_result(r_type(7'd0, `RV_F3_AND, 5'd4, 5'd2, 5'd3), a & b, "and");
    emit_result(r_type(7'd0, `RV_F3_SLL, 5'd4, 5'd2, 5'd3), a << 7, "sll");
    emit_result(r_type(7'd0, `RV_F3_SR, 5'd4, 5'd2, 5'd3), a >> 7, "srl");
    emit_result(r_type(`RV_F7_ALT, `RV_F3_SR, 5'd4, 5'd2, 5'd3),
                {{7{a[31]}}, a[31:7]}, "sra");
    emit_result(addi(5'd4, 5'd2, 12'd55), a + 32'd55, "addi");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_SLT, 5'd4, 5'd2, 12'hf38), 32'd0, "slti");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_SLTU, 5'd4, 5'd3, 12'hfff), 32'd1, "sltiu");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_XOR, 5'd4, 5'd2, 12'h0f0), a ^ 32'h0f0, "xori");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_XOR, 5'd4, 5'd2, 12'hfff), ~a, "xori -1");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_OR, 5'd4, 5'd2, 12'h333), a | 32'h333, "ori");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_AND, 5'd4, 5'd2, 12'h7ff), a & 32'h7ff, "andi");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_SLL, 5'd4, 5'd2, 12'd5), a << 5, "slli");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_SR, 5'd4, 5'd2, 12'd9), a >> 9, "srli");
    emit_result(i_type(`RV_OP_IMM, `RV_F3_SR, 5'd4, 5'd2, 12'h409),
                {{9{a[31]}}, a[31:9]}, "srai");
    // x0 swallows the write
    emit(addi(5'd0, 5'd3, 12'd5));
    store_result(5'd0, 32'd0, "x0");
    emit(ecall_insn());
    run_program("alu");
    check_results();
  endtask

  task automatic upper_imm_test();
    restart_core();
    emit(addi(5'd1, 5'd0, 12'h200));
    emit_result(u_type(`RV_OP_LUI, 5'd4, 20'habcde), 32'habcd_e000, "lui");
    emit_result(u_type(`RV_OP_AUIPC, 5'd4, 20'h12345), 32'h1234_5000 + pc_here(), "auipc");
    emit_result(u_type(`RV_OP_AUIPC, 5'd4, 20'hfffff), 32'hffff_f000 + pc_here(),
                "auipc negative");
    emit(ecall_insn());
    run_program("upper");
    check_results();
  endtask

  // marker 0x0a1 survives a taken branch, 0x0b2 marks fall-through
  task automatic branch_case(input riscv_pkg::funct3_t f3, input riscv_pkg::reg_addr_t rs1,
      input riscv_pkg::reg_addr_t rs2, input logic taken, input string name);
    emit(addi(5'd4, 5'd0, 12'h0a1));
    emit(b_type(f3, rs1, rs2, 13'd8));
    emit(addi(5'd4, 5'd0, 12'h0b2));
    store_result(5'd4, taken ? 32'h0a1 : 32'h0b2, name);
  endtask

  task automatic branch_jump_test();
    riscv_pkg::word_t link;
    restart_core();
    emit(addi(5'd1, 5'd0, 12'h200));
    emit(addi(5'd2, 5'd0, 12'hf9c));
    emit(addi(5'd3, 5'd0, 12'd7));
    emit(addi(5'd6, 5'd0, 12'd7));
    branch_case(`RV_F3_BEQ, 5'd3, 5'd6, 1'b1, "beq taken");
    branch_case(`RV_F3_BEQ, 5'd2, 5'd3, 1'b0, "beq not taken");
    branch_case(`RV_F3_BNE, 5'd2, 5'd3, 1'b1, "bne taken");
    branch_case(`RV_F3_BNE, 5'd3, 5'd6, 1'b0, "bne not taken");
    branch_case(`RV_F3_BLT, 5'd2, 5'd3, 1'b1, "blt taken");
    branch_case(`RV_F3_BLT, 5'd3, 5'd2, 1'b0, "blt not taken");
    branch_case(`RV_F3_BGE, 5'd3, 5'd6, 1'b1, "bge taken");
    branch_case(`RV_F3_BGE, 5'd2, 5'd3, 1'b0, "bge not taken");
    branch_case(`RV_F3_BLTU, 5'd3, 5'd2, 1'b1, "bltu taken");
    branch_case(`RV_F3_BLTU, 5'd2, 5'd3, 1'b0, "bltu not taken");
    branch_case(`RV_F3_BGEU, 5'd2, 5'd3, 1'b1, "bgeu taken");
    branch_case(`RV_F3_BGEU, 5'd3, 5'd2, 1'b0, "bgeu not taken");
    // jal over one instruction
    emit(addi(5'd4, 5'd0, 12'h0c1));
    link = pc_here() + 32'd4;
    emit(j_type(5'd7, 21'd8));
    emit(addi(5'd4, 5'd0, 12'h0d2));
    store_result(5'd4, 32'h0c1, "jal skip");
    store_result(5'd7, link, "jal link");
    // jalr to an odd offset drops bit 0
    emit(addi(5'd4, 5'd0, 12'h0e3));
    link = pc_here() + 32'd8;
    emit(u_type(`RV_OP_AUIPC, 5'd8, 20'h0));
    emit(i_type(`RV_OP_JALR, 3'b000, 5'd9, 5'd8, 12'd13));
    emit(addi(5'd4, 5'd0, 12'h0f4));
    store_result(5'd4, 32'h0e3, "jalr skip");
    store_result(5'd9, link, "jalr link");
    emit(ecall_insn());
    run_program("branch");
    check_results();
  endtask

  task automatic load_store_test();
    riscv_pkg::word_t preset;
    riscv_pkg::word_t src;
    riscv_pkg::word_t val;
    riscv_pkg::word_t exp;
    preset = 32'ha0b1_c2d3;
    src    = 32'h8a7b_f0c5;
    val    = 32'h8765_4321;
    restart_core();
    // store targets at 0x300, load source at 0x340
    for (int j = 0; j < 6; j++) begin
      mem[192 + j] <= preset;
    end
    mem[208] <= src;
    emit(addi(5'd1, 5'd0, 12'h200));
    emit(u_type(`RV_OP_LUI, 5'd10, 20'h87654));
    emit(addi(5'd10, 5'd10, 12'h321));
    for (int j = 0; j < 4; j++) begin
      emit(s_type(`RV_F3_BYTE, 5'd10, 5'd1, 12'(256 + 5 * j)));
    end
    emit(s_type(`RV_F3_HALF, 5'd10, 5'd1, 12'h110));
    emit(s_type(`RV_F3_HALF, 5'd10, 5'd1, 12'h116));
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_BYTE, 5'd4, 5'd1, 12'h140),
                {{24{src[7]}}, src[7:0]}, "lb lane 0");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_BYTE, 5'd4, 5'd1, 12'h142),
                {{24{src[23]}}, src[23:16]}, "lb lane 2");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_BYTE, 5'd4, 5'd1, 12'h143),
                {{24{src[31]}}, src[31:24]}, "lb lane 3");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_BYTE_U, 5'd4, 5'd1, 12'h140),
                {24'b0, src[7:0]}, "lbu lane 0");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_BYTE_U, 5'd4, 5'd1, 12'h143),
                {24'b0, src[31:24]}, "lbu lane 3");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_HALF, 5'd4, 5'd1, 12'h140),
                {{16{src[15]}}, src[15:0]}, "lh low");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_HALF, 5'd4, 5'd1, 12'h142),
                {{16{src[31]}}, src[31:16]}, "lh high");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_HALF_U, 5'd4, 5'd1, 12'h140),
                {16'b0, src[15:0]}, "lhu low");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_HALF_U, 5'd4, 5'd1, 12'h142),
                {16'b0, src[31:16]}, "lhu high");
    emit_result(i_type(`RV_OP_LOAD, `RV_F3_WORD, 5'd4, 5'd1, 12'h140), src, "lw");
    emit(ecall_insn());
    run_program("load_store");
    for (int j = 0; j < 4; j++) begin
      exp = preset;
      exp[8*j +: 8] = val[7:0];
      check_word($sformatf("mem[0x%03h] sb lane %0d", 32'h300 + 4 * j, j), mem[192 + j], exp);
    end
    check_word("mem[0x310] sh low", mem[196], {preset[31:16], val[15:0]});
    check_word("mem[0x314] sh high", mem[197], {val[15:0], preset[15:0]});
    check_results();
  endtask

  task automatic halt_test();
    riscv_pkg::word_t halt_pc;
    restart_core();
    emit(addi(5'd1, 5'd0, 12'h200));
    emit(addi(5'd4, 5'd0, 12'h05a));
    halt_pc = pc_here();
    emit(ecall_insn());
    emit(s_type(`RV_F3_WORD, 5'd4, 5'd1, 12'h000));
    run_program("halt");
    check_word("o_pc", pc, halt_pc);
    repeat (4) begin
      @(negedge clk);
      check_flag("o_halt", halt, 1'b1);
      check_word("o_pc", pc, halt_pc);
      check_strobe("o_store_we", store_we, 4'h0);
    end
    check_word("mem[0x200]", mem[RES_WORD], fill_word(RES_WORD));
  endtask

  initial begin
    test_rst = 1'b0;
    reset_test();
    alu_test();
    upper_imm_test();
    branch_jump_test();
    load_store_test();
    halt_test();
    errors += u_dut.u_props.fail_count;
    $display("riscv_core_tb: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_dut.u_props.fail_count);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // power-on reset released just after an edge
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule
